// File: nabp_stream_input.txt
// parameters: image size, partitions, frames, values per pattern
// then one pattern per frame of 16-bit signed values, repeated over the frame's beats
0008 0002 0004 000d
// frame 0
0001 0003 0007 000f 001f 003f 007f 00ff 0005 0011 0101 0009 0021
// frame 1
fffe 0100 ff80 0042 fff1 1234 edcc 0033 fc00 0777 ffff 0080 0010
// frame 2
7fff 8000 0001 fffd 2000 e000 0123 fedc 0456 fba9 0011 ffee 0a0a
// frame 3
0c0c f3f4 0055 ffab 0202 fdfe 0909 f6f7 1111 eeef 0303 fcfd 0040

// File: sources.f
nabp_pkg.sv
image_port_if.sv
image_addresser.sv
image_updater.sv
image_ram.sv
apb_image_regs.sv
nabp_image_top.sv
tb_nabp_image.sv

// File: run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f sources.f --top-module tb_nabp_image -o sim_nabp_image

./obj_dir/sim_nabp_image 2>&1 | tee sim.log

if grep -qx "Everything OK" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_nabp_image.sv
`timescale 1ns/10ps

module tb_nabp_image;

    localparam int IMAGE_SIZE       = 8;
    localparam int NO_OF_PARTITIONS = 2;
    localparam int VALUE_WIDTH      = 16;
    localparam int PIXEL_WIDTH      = 24;
    localparam int PART_SIZE        = IMAGE_SIZE / NO_OF_PARTITIONS;
    localparam int PIXELS           = IMAGE_SIZE * IMAGE_SIZE;
    localparam int FRAME_BEATS      = NO_OF_PARTITIONS * 2 * PART_SIZE * IMAGE_SIZE;
    localparam int CLK_PERIOD       = 100;
    localparam int POLL_LIMIT       = 500;

    logic                   clk;
    logic                   reset_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [3:0]             paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   stream_valid;
    logic [VALUE_WIDTH-1:0] stream_value;
    logic                   stream_ready;

    // words 0..3 are image size, partitions, frames, pattern length
    logic [15:0] stim_mem [256];
    int          ref_img [PIXELS];
    int          frames;
    int          pattern_len;
    int          errors;
    int          checks;
    int          tests_run;
    logic [31:0] rng;

    nabp_image_top #(
        .IMAGE_SIZE       (IMAGE_SIZE),
        .NO_OF_PARTITIONS (NO_OF_PARTITIONS),
        .VALUE_WIDTH      (VALUE_WIDTH),
        .PIXEL_WIDTH      (PIXEL_WIDTH)
    ) dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .stream_valid (stream_valid),
        .stream_value (stream_value),
        .stream_ready (stream_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // x scan of a band, then its y scan
    function automatic int beat_address(input int beat);
        int part;
        int r;
        int addr;
        part = beat / (2 * PART_SIZE * IMAGE_SIZE);
        r    = beat % (2 * PART_SIZE * IMAGE_SIZE);
        if (r < PART_SIZE * IMAGE_SIZE)
            addr = part * PART_SIZE * IMAGE_SIZE + (r / IMAGE_SIZE) * IMAGE_SIZE + r % IMAGE_SIZE;
        else
        begin
            r    = r - PART_SIZE * IMAGE_SIZE;
            addr = part * PART_SIZE + r / IMAGE_SIZE + (r % IMAGE_SIZE) * IMAGE_SIZE;
        end
        return addr;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("%s", what);
            errors++;
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        while (!pready)
        begin
            waits++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        check_value("pready wait states of write", 32'h0, 32'(waits));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // only img_data reads take a wait state
    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        while (!pready)
        begin
            waits++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        data = prdata;
        err  = pslverr;
        check_value("pready wait states of read",
                    (addr == nabp_pkg::reg_img_data) ? 32'h1 : 32'h0, 32'(waits));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle(input string what);
        logic [31:0] data;
        logic        err;
        int          polls;
        polls = 0;
        data  = 32'h3;
        while (data[1:0] != 2'b00 && polls < POLL_LIMIT)
        begin
            apb_read(nabp_pkg::reg_status, data, err);
            polls++;
        end
        check_true(data[1:0] == 2'b00, {what, " did not finish in time"});
    endtask

    task automatic compare_image();
        logic [31:0] data;
        logic        err;
        for (int a = 0; a < PIXELS; a++)
        begin
            apb_write(nabp_pkg::reg_img_addr, 32'(a));
            apb_read(nabp_pkg::reg_img_data, data, err);
            check_value($sformatf("prdata of pixel %0d", a), ref_img[a], data);
        end
    endtask

    // fill counts the cycles with ready low before the first ready
    task automatic drive_frame(input int frame, input bit random_gaps, output int fill);
        int          beat;
        bit          started;
        logic [15:0] v;
        beat    = 0;
        started = 1'b0;
        fill    = 0;
        while (beat < FRAME_BEATS)
        begin
            v            = stim_mem[4 + frame * pattern_len + beat % pattern_len];
            stream_value = v;
            if (random_gaps)
            begin
                rng          = xorshift32(rng);
                stream_valid = (rng[1:0] != 2'b00);
            end
            else
                stream_valid = 1'b1;
            #(CLK_PERIOD / 4);
            if (!started && !stream_ready)
                fill++;
            if (stream_ready)
                started = 1'b1;
            if (stream_valid && stream_ready)
            begin
                ref_img[beat_address(beat)] += int'($signed(v));
                beat++;
            end
            @(negedge clk);
        end
        stream_valid = 1'b0;
    endtask

    task automatic end_test(input int num, input string name, input int errors_before);
        tests_run++;
        $display("test %0d %s: %s", num, name, (errors == errors_before) ? "passed" : "failed");
    endtask

    initial
    begin
        int limit;
        #1;
        limit = frames * FRAME_BEATS * 4 + PIXELS * 2 + 2000;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d clock periods", limit);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        logic [31:0] data;
        logic        err;
        int          fill;
        int          mark;
        int          extra;
        $readmemh("nabp_stream_input.txt", stim_mem);
        frames       = int'(stim_mem[2]);
        pattern_len  = int'(stim_mem[3]);
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        rng          = 32'h13dea355;
        reset_n      = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 4'h0;
        pwdata       = 32'h0;
        stream_valid = 1'b0;
        stream_value = '0;
        foreach (ref_img[a])
            ref_img[a] = 0;
        repeat (5) @(negedge clk);
        reset_n = 1'b0;

        mark = errors;
        check_value("image size in input file", 32'(IMAGE_SIZE), 32'(stim_mem[0]));
        check_value("partitions in input file", 32'(NO_OF_PARTITIONS), 32'(stim_mem[1]));
        check_true(frames >= 4, "input file holds fewer than four frames");
        check_value("stream_ready", 32'h0, 32'(stream_ready));
        apb_read(nabp_pkg::reg_status, data, err);
        check_value("prdata of status", 32'h0, data);
        apb_read(4'h2, data, err);
        check_value("pslverr", 32'h1, 32'(err));
        end_test(1, "reset state", mark);

        mark = errors;
        apb_write(nabp_pkg::reg_ctrl, 32'h2);
        apb_read(nabp_pkg::reg_status, data, err);
        check_value("prdata of status", 32'h2, data);
        wait_idle("clear");
        compare_image();
        end_test(2, "clear", mark);

        mark = errors;
        apb_write(nabp_pkg::reg_ctrl, 32'h1);
        drive_frame(0, 1'b0, fill);
        check_value("ready low cycles after kick", 32'(NO_OF_PARTITIONS), 32'(fill));
        wait_idle("frame 0");
        compare_image();
        end_test(3, "frame without gaps", mark);

        mark = errors;
        apb_write(nabp_pkg::reg_ctrl, 32'h1);
        drive_frame(1, 1'b1, fill);
        wait_idle("frame 1");
        compare_image();
        end_test(4, "frame with valid gaps", mark);

        // second kick lands while the first frame is running
        mark = errors;
        apb_write(nabp_pkg::reg_ctrl, 32'h1);
        apb_read(nabp_pkg::reg_status, data, err);
        check_value("prdata of status", 32'h1, data);
        apb_write(nabp_pkg::reg_ctrl, 32'h1);
        drive_frame(2, 1'b1, fill);
        // a stored kick would reopen the stream right after the last beat
        extra        = 0;
        stream_valid = 1'b1;
        repeat (8)
        begin
            #(CLK_PERIOD / 4);
            if (stream_ready)
                extra++;
            @(negedge clk);
        end
        stream_valid = 1'b0;
        check_value("accepted beats after the frame", 32'h0, 32'(extra));
        wait_idle("frame 2");
        compare_image();
        end_test(5, "kick while busy", mark);

        mark = errors;
        apb_write(nabp_pkg::reg_ctrl, 32'h2);
        wait_idle("clear");
        foreach (ref_img[a])
            ref_img[a] = 0;
        apb_write(nabp_pkg::reg_ctrl, 32'h1);
        drive_frame(3, 1'b1, fill);
        wait_idle("frame 3");
        compare_image();
        end_test(6, "clear then frame", mark);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: nabp_image_top.sv
`timescale 1ns/10ps

module nabp_image_top #(
    parameter int IMAGE_SIZE       = 8,
    parameter int NO_OF_PARTITIONS = 2,
    parameter int VALUE_WIDTH      = 16,
    parameter int PIXEL_WIDTH      = 24
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   stream_valid,
    input  logic [VALUE_WIDTH-1:0] stream_value,
    output logic                   stream_ready
);

    localparam int ADDR_WIDTH = $clog2(IMAGE_SIZE * IMAGE_SIZE);

    logic                   kick;
    logic                   clear;
    logic                   busy;
    logic                   busy_addr;
    logic                   clearing;
    logic                   write_pending;
    logic                   accept;
    logic                   frame_done;
    logic [ADDR_WIDTH-1:0]  pixel_addr;
    logic                   rb_en;
    logic [ADDR_WIDTH-1:0]  rb_addr;
    logic [PIXEL_WIDTH-1:0] rb_data;

    image_port_if #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) image_port ();

    // frame runs until its last pixel is written back
    assign busy = busy_addr || write_pending;

    image_addresser #(
        .IMAGE_SIZE       (IMAGE_SIZE),
        .NO_OF_PARTITIONS (NO_OF_PARTITIONS)
    ) addresser_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .kick         (kick),
        .stream_valid (stream_valid),
        .stream_ready (stream_ready),
        .accept       (accept),
        .pixel_addr   (pixel_addr),
        .frame_done   (frame_done),
        .busy_addr    (busy_addr)
    );

    image_updater #(
        .IMAGE_SIZE  (IMAGE_SIZE),
        .VALUE_WIDTH (VALUE_WIDTH),
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) updater_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .accept        (accept),
        .pixel_addr    (pixel_addr),
        .frame_done    (frame_done),
        .value         (stream_value),
        .clear         (clear),
        .clearing      (clearing),
        .write_pending (write_pending),
        .ram           (image_port.updater)
    );

    image_ram #(
        .IMAGE_SIZE  (IMAGE_SIZE),
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) ram_i (
        .clk     (clk),
        .port    (image_port.ram),
        .rb_en   (rb_en),
        .rb_addr (rb_addr),
        .rb_data (rb_data)
    );

    apb_image_regs #(
        .IMAGE_SIZE  (IMAGE_SIZE),
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) regs_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .kick     (kick),
        .clear    (clear),
        .busy     (busy),
        .clearing (clearing),
        .rb_en    (rb_en),
        .rb_addr  (rb_addr),
        .rb_data  (rb_data)
    );

endmodule

// File: apb_image_regs.sv
`timescale 1ns/10ps

module apb_image_regs #(
    parameter int  IMAGE_SIZE  = 8,
    parameter int  PIXEL_WIDTH = 24,
    localparam int ADDR_WIDTH  = $clog2(IMAGE_SIZE * IMAGE_SIZE)
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   kick,
    output logic                   clear,
    input  logic                   busy,
    input  logic                   clearing,
    output logic                   rb_en,
    output logic [ADDR_WIDTH-1:0]  rb_addr,
    input  logic [PIXEL_WIDTH-1:0] rb_data
);

    nabp_pkg::apb_reg_e    reg_sel;
    logic                  access;
    logic                  wr_access;
    logic                  rd_access;
    logic                  ctrl_wr;
    logic                  data_rd;
    logic                  known_reg;
    logic                  data_wait;
    logic [ADDR_WIDTH-1:0] img_addr;

    assign reg_sel   = nabp_pkg::apb_reg_e'(paddr);
    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;
    assign ctrl_wr   = wr_access && (reg_sel == nabp_pkg::reg_ctrl);
    assign data_rd   = rd_access && (reg_sel == nabp_pkg::reg_img_data);

    // start and clear are dropped while the image is in use
    assign kick  = ctrl_wr && pwdata[0] && !pwdata[1] && !busy && !clearing;
    assign clear = ctrl_wr && pwdata[1] && !busy && !clearing;

    // first cycle of an img_data read fetches the pixel
    assign rb_en   = data_rd && !data_wait;
    assign rb_addr = img_addr;

    assign pready  = access && !(data_rd && !data_wait);
    assign pslverr = access && !known_reg;

    always_comb
    begin
        known_reg = 1'b1;
        prdata    = '0;
        case (reg_sel)
            nabp_pkg::reg_ctrl:
                prdata = '0;
            nabp_pkg::reg_status:
                prdata = {30'd0, clearing, busy};
            nabp_pkg::reg_img_addr:
                prdata = 32'(img_addr);
            nabp_pkg::reg_img_data:
                // pixels are signed sums
                prdata = 32'(signed'(rb_data));
            default:
                known_reg = 1'b0;
        endcase
        if (!rd_access || (data_rd && !data_wait))
            prdata = '0;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            data_wait <= 1'b0;
            img_addr  <= '0;
        end
        else
        begin
            data_wait <= data_rd && !data_wait;
            if (wr_access && reg_sel == nabp_pkg::reg_img_addr)
                img_addr <= pwdata[ADDR_WIDTH-1:0];
        end
    end

    a_one_wait_state: assert property (@(posedge clk) disable iff (reset_n)
        (psel && penable && !pready) |=> pready);

endmodule

// File: image_ram.sv
`timescale 1ns/10ps

module image_ram #(
    parameter int  IMAGE_SIZE  = 8,
    parameter int  PIXEL_WIDTH = 24,
    localparam int ADDR_WIDTH  = $clog2(IMAGE_SIZE * IMAGE_SIZE)
) (
    input  logic                   clk,
    image_port_if.ram              port,
    input  logic                   rb_en,
    input  logic [ADDR_WIDTH-1:0]  rb_addr,
    output logic [PIXEL_WIDTH-1:0] rb_data
);

    localparam int DEPTH = IMAGE_SIZE * IMAGE_SIZE;

    logic [PIXEL_WIDTH-1:0] mem [DEPTH];

    // accumulate port
    // a read that meets the write address returns the old contents,
    // the write lands in the same edge
    always_ff @(posedge clk)
    begin
        if (port.wr_en)
            mem[port.wr_addr] <= port.wr_data;
        if (port.rd_en)
            port.rd_data <= mem[port.rd_addr];
    end

    // readback port for software
    always_ff @(posedge clk)
    begin
        if (rb_en)
            rb_data <= mem[rb_addr];
    end

endmodule

// File: image_updater.sv
`timescale 1ns/10ps

module image_updater #(
    parameter int  IMAGE_SIZE  = 8,
    parameter int  VALUE_WIDTH = 16,
    parameter int  PIXEL_WIDTH = 24,
    localparam int ADDR_WIDTH  = $clog2(IMAGE_SIZE * IMAGE_SIZE)
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   accept,
    input  logic [ADDR_WIDTH-1:0]  pixel_addr,
    input  logic                   frame_done,
    input  logic [VALUE_WIDTH-1:0] value,
    input  logic                   clear,
    output logic                   clearing,
    output logic                   write_pending,
    image_port_if.updater          ram
);

    localparam int LAST_ADDR = IMAGE_SIZE * IMAGE_SIZE - 1;

    // stage 1 reads the pixel, stage 2 writes the sum
    logic                   s1_valid;
    logic                   s1_last;
    logic [ADDR_WIDTH-1:0]  s1_addr;
    logic [PIXEL_WIDTH-1:0] s1_value;
    logic                   s2_valid;
    logic                   s2_last;
    logic [ADDR_WIDTH-1:0]  s2_addr;
    logic [PIXEL_WIDTH-1:0] s2_value;
    logic [ADDR_WIDTH-1:0]  clear_addr;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
        end
        else
        begin
            s1_valid <= accept;
            s1_last  <= frame_done;
            s2_valid <= s1_valid;
            s2_last  <= s1_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s1_addr  <= pixel_addr;
            s1_value <= PIXEL_WIDTH'(signed'(value));
        end
        s2_addr  <= s1_addr;
        s2_value <= s1_value;
    end

    // held from the first beat until the last beat of the frame is written
    always_ff @(posedge clk)
    begin
        if (reset_n)
            write_pending <= 1'b0;
        else if (accept)
            write_pending <= 1'b1;
        else if (s2_valid && s2_last)
            write_pending <= 1'b0;
    end

    // zero fill, one pixel per cycle
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            clearing   <= 1'b0;
            clear_addr <= '0;
        end
        else if (clear)
        begin
            clearing   <= 1'b1;
            clear_addr <= '0;
        end
        else if (clearing)
        begin
            if (clear_addr == ADDR_WIDTH'(LAST_ADDR))
                clearing <= 1'b0;
            clear_addr <= clear_addr + 1'b1;
        end
    end

    assign ram.rd_en   = s1_valid;
    assign ram.rd_addr = s1_addr;
    assign ram.wr_en   = s2_valid || clearing;
    assign ram.wr_addr = clearing ? clear_addr : s2_addr;
    assign ram.wr_data = clearing ? '0 : ram.rd_data + s2_value;

    // back to back beats never hit the same pixel, so no forwarding path
    a_distinct_addr: assert property (@(posedge clk) disable iff (reset_n)
        (accept && s1_valid) |-> (pixel_addr != s1_addr));

    // the stream is stalled for the whole zero fill
    a_no_update_in_clear: assert property (@(posedge clk) disable iff (reset_n)
        clearing |-> !accept && !s2_valid);

endmodule

// File: image_addresser.sv
`timescale 1ns/10ps

module image_addresser #(
    parameter int  IMAGE_SIZE       = 8,
    parameter int  NO_OF_PARTITIONS = 2,
    localparam int ADDR_WIDTH       = $clog2(IMAGE_SIZE * IMAGE_SIZE)
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  kick,
    input  logic                  stream_valid,
    output logic                  stream_ready,
    output logic                  accept,
    output logic [ADDR_WIDTH-1:0] pixel_addr,
    output logic                  frame_done,
    output logic                  busy_addr
);

    localparam int PART_SIZE  = IMAGE_SIZE / NO_OF_PARTITIONS;
    localparam int SCAN_WIDTH = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;
    localparam int LINE_WIDTH = (PART_SIZE > 1) ? $clog2(PART_SIZE) : 1;
    localparam int PE_WIDTH   = (NO_OF_PARTITIONS > 1) ? $clog2(NO_OF_PARTITIONS) : 1;

    nabp_pkg::addresser_state_e state;
    nabp_pkg::addresser_state_e next_state;

    // pe_pos counts the chain fill in delay, then the partition
    logic [PE_WIDTH-1:0]   pe_pos;
    logic [SCAN_WIDTH-1:0] scan_pos;
    logic [LINE_WIDTH-1:0] line_pos;
    logic [ADDR_WIDTH-1:0] base_addr;
    logic [ADDR_WIDTH-1:0] off_x;
    logic [ADDR_WIDTH-1:0] off_y;
    logic                  pe_done;
    logic                  scan_done;
    logic                  line_done;
    logic                  block_done;

    assign pe_done    = (pe_pos == PE_WIDTH'(NO_OF_PARTITIONS - 1));
    assign scan_done  = (scan_pos == SCAN_WIDTH'(IMAGE_SIZE - 1));
    assign line_done  = (line_pos == LINE_WIDTH'(PART_SIZE - 1));
    // last beat of the current x or y scan
    assign block_done = accept && scan_done && line_done;

    assign stream_ready = (state == nabp_pkg::addressing_x_s) ||
                          (state == nabp_pkg::addressing_y_s);
    assign accept       = stream_valid && stream_ready;
    assign busy_addr    = (state != nabp_pkg::ready_s);
    assign frame_done   = block_done && pe_done && (state == nabp_pkg::addressing_y_s);

    assign pixel_addr = base_addr +
                        ((state == nabp_pkg::addressing_y_s) ? off_y : off_x);

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= nabp_pkg::ready_s;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready_s:
                if (kick)
                    next_state = nabp_pkg::delay_s;
            nabp_pkg::delay_s:
                if (pe_done)
                    next_state = nabp_pkg::addressing_x_s;
            nabp_pkg::addressing_x_s:
                if (block_done)
                    next_state = nabp_pkg::addressing_y_s;
            nabp_pkg::addressing_y_s:
                if (block_done)
                    next_state = pe_done ? nabp_pkg::ready_s : nabp_pkg::addressing_x_s;
            default:
                next_state = nabp_pkg::ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n || state == nabp_pkg::ready_s)
        begin
            pe_pos    <= '0;
            scan_pos  <= '0;
            line_pos  <= '0;
            base_addr <= '0;
            off_x     <= '0;
            off_y     <= '0;
        end
        else if (state == nabp_pkg::delay_s)
        begin
            // restart at partition 0 once the chain is full
            pe_pos <= pe_done ? '0 : pe_pos + 1'b1;
        end
        else if (accept)
        begin
            scan_pos <= scan_done ? '0 : scan_pos + 1'b1;
            if (scan_done)
                line_pos <= line_done ? '0 : line_pos + 1'b1;

            if (block_done)
                base_addr <= '0;
            else if (state == nabp_pkg::addressing_x_s)
                base_addr <= base_addr + 1'b1;
            else if (scan_done)
                // next column of the band
                base_addr <= ADDR_WIDTH'(line_pos) + 1'b1;
            else
                base_addr <= base_addr + ADDR_WIDTH'(IMAGE_SIZE);

            // step to the next band after its y scan
            if (block_done && state == nabp_pkg::addressing_y_s)
            begin
                pe_pos <= pe_pos + 1'b1;
                off_x  <= off_x + ADDR_WIDTH'(PART_SIZE * IMAGE_SIZE);
                off_y  <= off_y + ADDR_WIDTH'(PART_SIZE);
            end
        end
    end

    a_addr_in_range: assert property (@(posedge clk) disable iff (reset_n)
        accept |-> (32'(pixel_addr) < IMAGE_SIZE * IMAGE_SIZE));

    // each band scan runs from its own row and column offsets
    a_band_offsets: assert property (@(posedge clk) disable iff (reset_n)
        stream_ready |->
            (off_x == ADDR_WIDTH'(32'(pe_pos) * PART_SIZE * IMAGE_SIZE)) &&
            (off_y == ADDR_WIDTH'(32'(pe_pos) * PART_SIZE)));

endmodule

// File: image_port_if.sv
`timescale 1ns/10ps

// accumulate port of the image RAM
interface image_port_if #(
    parameter int ADDR_WIDTH  = 6,
    parameter int PIXEL_WIDTH = 24
);

    logic                   rd_en;
    logic [ADDR_WIDTH-1:0]  rd_addr;
    logic [PIXEL_WIDTH-1:0] rd_data;
    logic                   wr_en;
    logic [ADDR_WIDTH-1:0]  wr_addr;
    logic [PIXEL_WIDTH-1:0] wr_data;

    modport updater (
        output rd_en, rd_addr, wr_en, wr_addr, wr_data,
        input  rd_data
    );

    modport ram (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
        output rd_data
    );

endinterface

// File: nabp_pkg.sv
package nabp_pkg;

    // image addresser FSM
    // ready waits for a kick, delay covers the chain fill,
    // then each partition is scanned along x and then along y
    typedef enum logic [1:0] {
        ready_s        = 2'd0,
        delay_s        = 2'd1,
        addressing_x_s = 2'd2,
        addressing_y_s = 2'd3
    } addresser_state_e;

    // APB register offsets
    // ctrl: bit 0 starts a frame, bit 1 clears the image
    // status: bit 0 busy, bit 1 clearing
    // img_addr: pixel address for readback
    // img_data: pixel value at img_addr, one wait state
    typedef enum logic [3:0] {
        reg_ctrl     = 4'h0,
        reg_status   = 4'h4,
        reg_img_addr = 4'h8,
        reg_img_data = 4'hC
    } apb_reg_e;

endpackage
